// ==== hw/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

   // word and address geometry
   localparam int DATA_W        = 32;
   localparam int NBYTES        = DATA_W / 8;
   localparam int ADDR_W        = 10;

   // 4 words per line
   localparam int WORD_OFFSET_W = 2;
   localparam int NWORDS        = 2 ** WORD_OFFSET_W;

   // 8 sets
   localparam int NLINES_W      = 3;
   localparam int NLINES        = 2 ** NLINES_W;

   // what is left of the address above index and offset
   localparam int TAG_W         = ADDR_W - NLINES_W - WORD_OFFSET_W;

   // two ways
   localparam int NWAYS_W       = 1;
   localparam int NWAYS         = 2 ** NWAYS_W;

   typedef enum logic [1:0] {
      IDLE,
      LOOKUP,
      REFILL,
      WRITE_THRU
   } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hw/mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

   // line address, one line per back-end beat
   localparam int BE_ADDR_W   = 8;

   // 4 words of 32 bits
   localparam int LINE_W      = 128;

   // one strobe per byte of the line
   localparam int LINE_STRB_W = 16;

endpackage

`default_nettype wire

// ==== hw/prio_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module prio_encoder
   import cache_pkg::*;
(
   input  logic [NWAYS-1:0]   unencoded_i,
   output logic [NWAYS_W-1:0] encoded_o
);

   // scan downwards so the lowest set bit wins
   always_comb begin
      encoded_o = '0;
      for (int i = NWAYS - 1; i >= 0; i--) begin
         if (unencoded_i[i]) begin
            encoded_o = NWAYS_W'(i);
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/cache_dmem.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_dmem
   import cache_pkg::*;
   import mem_bus_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              lookup_i,
   input  logic [ADDR_W-1:0] addr_i,
   input  logic              refill_i,
   input  logic [LINE_W-1:0] refill_line_i,
   input  logic              wr_hit_upd_i,
   input  logic [DATA_W-1:0] wdata_i,
   input  logic [NBYTES-1:0] wstrb_i,
   input  logic              invalidate_i,
   output logic              hit_o,
   output logic [DATA_W-1:0] rdata_o,
   output logic              rd_hit_o,
   output logic              rd_miss_o,
   output logic              wr_hit_o,
   output logic              wr_miss_o
);

   // tag on top of the line, all ways of a set side by side
   logic [NWAYS-1:0][TAG_W+LINE_W-1:0] mem [NLINES];
   logic [NWAYS-1:0][TAG_W+LINE_W-1:0] set_rd;

   logic [NLINES-1:0][NWAYS-1:0]   valid_r;
   logic [NLINES-1:0][NWAYS_W-1:0] rr_r;

   logic [ADDR_W-1:0] addr_r;
   logic [DATA_W-1:0] wdata_r;
   logic [NBYTES-1:0] wstrb_r;
   logic              rd_r;
   logic              wr_r;
   logic              lookup_r;

   logic [TAG_W-1:0]         tag_r;
   logic [NLINES_W-1:0]      idx_r;
   logic [WORD_OFFSET_W-1:0] off_r;

   logic [NWAYS-1:0]   way_hit_1hot;
   logic [NWAYS_W-1:0] way_hit;
   logic [NWAYS_W-1:0] way_free;
   logic [NWAYS_W-1:0] fill_way;
   logic               all_valid;

   assign tag_r    = addr_r[ADDR_W-1 -: TAG_W];
   assign idx_r    = addr_r[WORD_OFFSET_W +: NLINES_W];
   assign off_r    = addr_r[WORD_OFFSET_W-1:0];
   assign lookup_r = rd_r | wr_r;

   // kind of request, high only in the lookup cycle
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rd_r <= 1'b0;
         wr_r <= 1'b0;
      end else begin
         rd_r <= lookup_i & ~|wstrb_i;
         wr_r <= lookup_i & |wstrb_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (lookup_i) begin
         addr_r  <= addr_i;
         wdata_r <= wdata_i;
         wstrb_r <= wstrb_i;
      end
   end

   for (genvar w = 0; w < NWAYS; w++) begin : g_way
      assign way_hit_1hot[w] = valid_r[idx_r][w] && (set_rd[w][LINE_W +: TAG_W] == tag_r);
   end

   prio_encoder hit_enc (
      .unencoded_i(way_hit_1hot),
      .encoded_o  (way_hit)
   );

   prio_encoder free_enc (
      .unencoded_i(~valid_r[idx_r]),
      .encoded_o  (way_free)
   );

   // free way first, round-robin victim once the set is full
   assign all_valid = &valid_r[idx_r];
   assign fill_way  = all_valid ? rr_r[idx_r] : way_free;

   assign hit_o     = |way_hit_1hot;
   assign rdata_o   = set_rd[way_hit][off_r*DATA_W +: DATA_W];
   assign rd_hit_o  = rd_r & hit_o;
   assign rd_miss_o = rd_r & ~hit_o;
   assign wr_hit_o  = wr_r & hit_o;
   assign wr_miss_o = wr_r & ~hit_o;

   always_ff @(posedge clk_i) begin
      if (lookup_i) begin
         set_rd <= mem[addr_i[WORD_OFFSET_W +: NLINES_W]];
      end
      if (refill_i) begin
         mem[idx_r][fill_way] <= {tag_r, refill_line_i};
      end
      if (wr_hit_upd_i) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (wstrb_r[b]) begin
               mem[idx_r][way_hit][off_r*DATA_W + b*8 +: 8] <= wdata_r[b*8 +: 8];
            end
         end
      end
   end

   // no invalidate in the lookup cycle or the refill cycle
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         valid_r <= '0;
         rr_r    <= '0;
      end else if (refill_i) begin
         valid_r[idx_r][fill_way] <= 1'b1;
         if (all_valid) begin
            rr_r[idx_r] <= rr_r[idx_r] + NWAYS_W'(1);
         end
      end else if (invalidate_i && !lookup_r) begin
         valid_r <= '0;
      end
   end

   // a refill never places a tag already present in the set
   assert property (@(posedge clk_i) disable iff (rst_i)
      lookup_r |-> $onehot0(way_hit_1hot));

   assert property (@(posedge clk_i) disable iff (rst_i)
      !(refill_i && wr_hit_upd_i));

endmodule

`default_nettype wire

// ==== hw/cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
   import cache_pkg::*;
   import mem_bus_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   iob_avalid_i,
   input  logic [ADDR_W-1:0]      iob_addr_i,
   input  logic [DATA_W-1:0]      iob_wdata_i,
   input  logic [NBYTES-1:0]      iob_wstrb_i,
   output logic                   iob_ready_o,
   output logic                   iob_rvalid_o,
   output logic [DATA_W-1:0]      iob_rdata_o,
   input  logic                   hit_i,
   input  logic [DATA_W-1:0]      rdata_i,
   output logic                   lookup_o,
   output logic                   refill_o,
   output logic [LINE_W-1:0]      refill_line_o,
   output logic                   wr_hit_upd_o,
   output logic                   be_avalid_o,
   output logic [BE_ADDR_W-1:0]   be_addr_o,
   output logic [LINE_W-1:0]      be_wdata_o,
   output logic [LINE_STRB_W-1:0] be_wstrb_o,
   input  logic                   be_ready_i,
   input  logic [LINE_W-1:0]      be_rdata_i,
   input  logic                   be_rvalid_i
);

   ctrl_state_t state_r;
   ctrl_state_t state_nxt;

   logic [ADDR_W-1:0]        addr_r;
   logic [DATA_W-1:0]        wdata_r;
   logic [NBYTES-1:0]        wstrb_r;
   logic [WORD_OFFSET_W-1:0] off;
   logic                     is_wr;
   logic                     be_acc_r;
   logic                     rvalid_r;
   logic [DATA_W-1:0]        rdata_r;

   assign off   = addr_r[WORD_OFFSET_W-1:0];
   assign is_wr = |wstrb_r;

   assign iob_ready_o   = (state_r == IDLE);
   assign lookup_o      = iob_avalid_i & iob_ready_o;
   assign wr_hit_upd_o  = (state_r == LOOKUP) & is_wr & hit_i;
   assign refill_o      = (state_r == REFILL) & be_rvalid_i;
   assign refill_line_o = be_rdata_i;

   // hit answers straight from the array, refill one cycle later
   assign iob_rvalid_o = ((state_r == LOOKUP) & ~is_wr & hit_i) | rvalid_r;
   assign iob_rdata_o  = rvalid_r ? rdata_r : rdata_i;

   assign be_avalid_o = ((state_r == LOOKUP) & (is_wr | ~hit_i)) |
                        (state_r == WRITE_THRU) |
                        ((state_r == REFILL) & ~be_acc_r);
   assign be_addr_o   = addr_r[ADDR_W-1:WORD_OFFSET_W];
   // word and strobes moved to the word's slot in the line
   assign be_wdata_o  = LINE_W'(wdata_r) << (off * DATA_W);
   assign be_wstrb_o  = LINE_STRB_W'(wstrb_r) << (off * NBYTES);

   always_ff @(posedge clk_i) begin
      if (lookup_o) begin
         addr_r  <= iob_addr_i;
         wdata_r <= iob_wdata_i;
         wstrb_r <= iob_wstrb_i;
      end
      if (refill_o) begin
         rdata_r <= be_rdata_i[off*DATA_W +: DATA_W];
      end
   end

   always_comb begin
      state_nxt = state_r;
      case (state_r)
         IDLE: begin
            if (lookup_o) begin
               state_nxt = LOOKUP;
            end
         end
         LOOKUP: begin
            if (is_wr) begin
               state_nxt = be_ready_i ? IDLE : WRITE_THRU;
            end else begin
               state_nxt = hit_i ? IDLE : REFILL;
            end
         end
         REFILL: begin
            if (be_rvalid_i) begin
               state_nxt = IDLE;
            end
         end
         WRITE_THRU: begin
            if (be_ready_i) begin
               state_nxt = IDLE;
            end
         end
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_r  <= IDLE;
         be_acc_r <= 1'b0;
         rvalid_r <= 1'b0;
      end else begin
         state_r  <= state_nxt;
         rvalid_r <= refill_o;
         // line read address taken, now waiting for the data
         if (state_r == IDLE) begin
            be_acc_r <= 1'b0;
         end else if (be_avalid_o && be_ready_i) begin
            be_acc_r <= 1'b1;
         end
      end
   end

   assert property (@(posedge clk_i) disable iff (rst_i)
      iob_rvalid_o |-> (state_r == LOOKUP) || ($past(state_r) == REFILL));

   assert property (@(posedge clk_i) disable iff (rst_i)
      be_avalid_o && !be_ready_i |=> be_avalid_o);

endmodule

`default_nettype wire

// ==== hw/cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_top
   import cache_pkg::*;
   import mem_bus_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   iob_avalid_i,
   input  logic [ADDR_W-1:0]      iob_addr_i,
   input  logic [DATA_W-1:0]      iob_wdata_i,
   input  logic [NBYTES-1:0]      iob_wstrb_i,
   output logic                   iob_ready_o,
   output logic [DATA_W-1:0]      iob_rdata_o,
   output logic                   iob_rvalid_o,
   output logic                   be_avalid_o,
   output logic [BE_ADDR_W-1:0]   be_addr_o,
   output logic [LINE_W-1:0]      be_wdata_o,
   output logic [LINE_STRB_W-1:0] be_wstrb_o,
   input  logic                   be_ready_i,
   input  logic [LINE_W-1:0]      be_rdata_i,
   input  logic                   be_rvalid_i,
   input  logic                   invalidate_i,
   output logic                   rd_hit_o,
   output logic                   rd_miss_o,
   output logic                   wr_hit_o,
   output logic                   wr_miss_o
);

   logic              lookup;
   logic              refill;
   logic [LINE_W-1:0] refill_line;
   logic              wr_hit_upd;
   logic              hit;
   logic [DATA_W-1:0] dmem_rdata;

   cache_ctrl ctrl (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .iob_avalid_i (iob_avalid_i),
      .iob_addr_i   (iob_addr_i),
      .iob_wdata_i  (iob_wdata_i),
      .iob_wstrb_i  (iob_wstrb_i),
      .iob_ready_o  (iob_ready_o),
      .iob_rvalid_o (iob_rvalid_o),
      .iob_rdata_o  (iob_rdata_o),
      .hit_i        (hit),
      .rdata_i      (dmem_rdata),
      .lookup_o     (lookup),
      .refill_o     (refill),
      .refill_line_o(refill_line),
      .wr_hit_upd_o (wr_hit_upd),
      .be_avalid_o  (be_avalid_o),
      .be_addr_o    (be_addr_o),
      .be_wdata_o   (be_wdata_o),
      .be_wstrb_o   (be_wstrb_o),
      .be_ready_i   (be_ready_i),
      .be_rdata_i   (be_rdata_i),
      .be_rvalid_i  (be_rvalid_i)
   );

   // address and write data are captured inside on lookup
   cache_dmem dmem (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .lookup_i     (lookup),
      .addr_i       (iob_addr_i),
      .refill_i     (refill),
      .refill_line_i(refill_line),
      .wr_hit_upd_i (wr_hit_upd),
      .wdata_i      (iob_wdata_i),
      .wstrb_i      (iob_wstrb_i),
      .invalidate_i (invalidate_i),
      .hit_o        (hit),
      .rdata_o      (dmem_rdata),
      .rd_hit_o     (rd_hit_o),
      .rd_miss_o    (rd_miss_o),
      .wr_hit_o     (wr_hit_o),
      .wr_miss_o    (wr_miss_o)
   );

endmodule

`default_nettype wire

// ==== testbench/tb_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cache
   import cache_pkg::*;
   import mem_bus_pkg::*;
();

   logic                   clk_i;
   logic                   rst_i;
   logic                   iob_avalid_i;
   logic [ADDR_W-1:0]      iob_addr_i;
   logic [DATA_W-1:0]      iob_wdata_i;
   logic [NBYTES-1:0]      iob_wstrb_i;
   logic                   iob_ready_o;
   logic [DATA_W-1:0]      iob_rdata_o;
   logic                   iob_rvalid_o;
   logic                   be_avalid_o;
   logic [BE_ADDR_W-1:0]   be_addr_o;
   logic [LINE_W-1:0]      be_wdata_o;
   logic [LINE_STRB_W-1:0] be_wstrb_o;
   logic                   be_ready_i;
   logic [LINE_W-1:0]      be_rdata_i;
   logic                   be_rvalid_i;
   logic                   invalidate_i;
   logic                   rd_hit_o;
   logic                   rd_miss_o;
   logic                   wr_hit_o;
   logic                   wr_miss_o;

   // main memory and cache bookkeeping of the reference model
   logic [LINE_W-1:0]             mem_model [256];
   logic [TAG_W-1:0]              tag_m [NLINES][NWAYS];
   logic [NLINES-1:0][NWAYS-1:0]  valid_m;
   logic [NLINES-1:0]             rr_m;

   logic [31:0] seed;
   logic [31:0] r;
   int          errors;
   int          errs_at_start;
   int          tests_run;
   int          tests_failed;
   string       test_name;

   cache_top UUT (.*);

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   function automatic logic [15:0] rand16();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed[31:16];
   endfunction

   function automatic logic [31:0] rand32();
      logic [15:0] hi;
      hi = rand16();
      return {hi, rand16()};
   endfunction

   task automatic report_value(string what, logic [31:0] exp, logic [31:0] act);
      $display("Error %s: %s expected %h actual %h", test_name, what, exp, act);
      errors++;
   endtask

   task automatic report_text(string msg);
      $display("%s: %s", test_name, msg);
      errors++;
   endtask

   task automatic start_test(string name);
      test_name = name;
      errs_at_start = errors;
   endtask

   task automatic end_test();
      tests_run++;
      if (errors == errs_at_start) begin
         $display("test %s: ok", test_name);
      end else begin
         $display("test %s: %0d errors", test_name, errors - errs_at_start);
         tests_failed++;
      end
   endtask

   task automatic wait_ready();
      int n;
      n = 0;
      while (iob_ready_o !== 1'b1) begin
         @(negedge clk_i);
         n++;
         if (n > 20) begin
            $display("timeout: front end never returned to ready in %s", test_name);
            $display("=== FAIL ===");
            $finish;
         end
      end
   endtask

   task automatic pulse_invalidate();
      wait_ready();
      invalidate_i = 1'b1;
      @(posedge clk_i);
      @(negedge clk_i);
      invalidate_i = 1'b0;
      valid_m = '0;
   endtask

   // one front-end request with the back end answered after random delays
   task automatic do_op(logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] wdata,
                        logic [NBYTES-1:0] wstrb);
      logic [TAG_W-1:0]         tag;
      logic [NLINES_W-1:0]      idx;
      logic [WORD_OFFSET_W-1:0] off;
      logic [BE_ADDR_W-1:0]     line;
      logic                     hit;
      logic                     way;
      logic [3:0]               exp_strb;
      logic [LINE_STRB_W-1:0]   exp_lstrb;
      logic [DATA_W-1:0]        exp_word;
      int                       d;
      tag  = addr[ADDR_W-1 -: TAG_W];
      idx  = addr[WORD_OFFSET_W +: NLINES_W];
      off  = addr[WORD_OFFSET_W-1:0];
      line = addr[ADDR_W-1:WORD_OFFSET_W];
      hit  = 1'b0;
      for (int w = 0; w < NWAYS; w++) begin
         if (valid_m[idx][w] && tag_m[idx][w] == tag) begin
            hit = 1'b1;
         end
      end
      if (wstrb == '0) begin
         exp_strb = hit ? 4'b1000 : 4'b0100;
      end else begin
         exp_strb = hit ? 4'b0010 : 4'b0001;
      end
      wait_ready();
      iob_avalid_i = 1'b1;
      iob_addr_i   = addr;
      iob_wdata_i  = wdata;
      iob_wstrb_i  = wstrb;
      @(posedge clk_i);
      @(negedge clk_i);
      iob_avalid_i = 1'b0;
      iob_wstrb_i  = '0;
      if ({rd_hit_o, rd_miss_o, wr_hit_o, wr_miss_o} !== exp_strb) begin
         report_value("strobes", 32'(exp_strb),
                      32'({rd_hit_o, rd_miss_o, wr_hit_o, wr_miss_o}));
      end
      if (wstrb == '0 && hit) begin
         exp_word = mem_model[line][off*DATA_W +: DATA_W];
         if (iob_rvalid_o !== 1'b1) begin
            report_text("no rvalid one cycle after a read hit");
         end else if (iob_rdata_o !== exp_word) begin
            report_value("hit rdata", exp_word, iob_rdata_o);
         end
      end else begin
         if (be_avalid_o !== 1'b1) begin
            report_text("no back-end request in the cycle after acceptance");
         end
         d = rand16() % 4;
         repeat (d) begin
            @(negedge clk_i);
            if (be_avalid_o !== 1'b1) begin
               report_text("back-end request dropped before ready");
            end
         end
         be_ready_i = 1'b1;
         if (be_addr_o !== line) begin
            report_value("be_addr", 32'(line), 32'(be_addr_o));
         end
         if (wstrb != '0) begin
            // only the written word may be strobed on the line
            exp_lstrb = '0;
            for (int b = 0; b < NBYTES; b++) begin
               exp_lstrb[off*NBYTES + b] = wstrb[b];
               if (wstrb[b]) begin
                  mem_model[line][off*DATA_W + b*8 +: 8] = wdata[b*8 +: 8];
                  if (be_wdata_o[off*DATA_W + b*8 +: 8] !== wdata[b*8 +: 8]) begin
                     report_value("be_wdata byte", 32'(wdata[b*8 +: 8]),
                                  32'(be_wdata_o[off*DATA_W + b*8 +: 8]));
                  end
               end
            end
            if (be_wstrb_o !== exp_lstrb) begin
               report_value("be_wstrb", 32'(exp_lstrb), 32'(be_wstrb_o));
            end
         end
         @(posedge clk_i);
         @(negedge clk_i);
         be_ready_i = 1'b0;
         if (wstrb != '0 && iob_ready_o !== 1'b1) begin
            report_text("front end not ready in the cycle after the write completed");
         end
         if (wstrb == '0) begin
            if (be_avalid_o !== 1'b0) begin
               report_text("back-end request still high after it was accepted");
            end
            d = rand16() % 4;
            repeat (d) @(negedge clk_i);
            be_rvalid_i = 1'b1;
            be_rdata_i  = mem_model[line];
            @(posedge clk_i);
            @(negedge clk_i);
            be_rvalid_i = 1'b0;
            // free way first, then the round-robin victim
            if (!valid_m[idx][0]) begin
               way = 1'b0;
            end else if (!valid_m[idx][1]) begin
               way = 1'b1;
            end else begin
               way      = rr_m[idx];
               rr_m[idx] = ~rr_m[idx];
            end
            valid_m[idx][way] = 1'b1;
            tag_m[idx][way]   = tag;
            exp_word = mem_model[line][off*DATA_W +: DATA_W];
            if (iob_rvalid_o !== 1'b1) begin
               report_text("no rvalid in the cycle after the refill");
            end else if (iob_rdata_o !== exp_word) begin
               report_value("refill rdata", exp_word, iob_rdata_o);
            end
         end
      end
   endtask

   initial begin
      seed          = 32'h57e0;
      errors        = 0;
      tests_run     = 0;
      tests_failed  = 0;
      rst_i         = 1'b1;
      iob_avalid_i  = 1'b0;
      iob_addr_i    = '0;
      iob_wdata_i   = '0;
      iob_wstrb_i   = '0;
      be_ready_i    = 1'b0;
      be_rdata_i    = '0;
      be_rvalid_i   = 1'b0;
      invalidate_i  = 1'b0;
      valid_m       = '0;
      rr_m          = '0;
      for (int a = 0; a < 1024; a++) begin
         mem_model[a/4][(a%4)*DATA_W +: DATA_W] = (32'(a) * 32'h9e3779b1) ^ 32'h5a5a0000;
      end
      repeat (3) @(negedge clk_i);
      rst_i = 1'b0;

      start_test("reset");
      if ({iob_ready_o, iob_rvalid_o, be_avalid_o} !== 3'b100) begin
         report_value("ready/rvalid/be_avalid", 32'h4, 32'({iob_ready_o, iob_rvalid_o, be_avalid_o}));
      end
      if ({rd_hit_o, rd_miss_o, wr_hit_o, wr_miss_o} !== 4'b0000) begin
         report_value("strobes", 32'h0, 32'({rd_hit_o, rd_miss_o, wr_hit_o, wr_miss_o}));
      end
      end_test();

      start_test("read miss then hit");
      do_op(10'h024, '0, 4'h0);
      do_op(10'h024, '0, 4'h0);
      end_test();

      start_test("write hit");
      do_op(10'h024, rand32(), 4'b0101);
      do_op(10'h024, '0, 4'h0);
      end_test();

      start_test("write miss");
      do_op({5'd9, 3'd2, 2'd3}, rand32(), 4'b1111);
      do_op({5'd9, 3'd2, 2'd3}, '0, 4'h0);
      end_test();

      // three tags fighting over set 5
      start_test("conflict");
      do_op({5'd1, 3'd5, 2'd1}, '0, 4'h0);
      do_op({5'd2, 3'd5, 2'd1}, '0, 4'h0);
      do_op({5'd3, 3'd5, 2'd1}, '0, 4'h0);
      do_op({5'd1, 3'd5, 2'd1}, '0, 4'h0);
      do_op({5'd3, 3'd5, 2'd2}, '0, 4'h0);
      do_op({5'd2, 3'd5, 2'd1}, '0, 4'h0);
      end_test();

      start_test("invalidate");
      pulse_invalidate();
      do_op(10'h024, '0, 4'h0);
      do_op({5'd9, 3'd2, 2'd3}, '0, 4'h0);
      do_op({5'd1, 3'd5, 2'd0}, '0, 4'h0);
      do_op({5'd2, 3'd5, 2'd3}, '0, 4'h0);
      end_test();

      start_test("random mix");
      for (int i = 0; i < 300; i++) begin
         r = rand32();
         if (r[20:16] == 5'd0) begin
            pulse_invalidate();
         end
         if (r[9:8] == 2'b00) begin
            do_op({3'b000, r[1:0], r[4:2], r[6:5]}, rand32(),
                  (r[14:11] == 4'h0) ? 4'hf : r[14:11]);
         end else begin
            do_op({3'b000, r[1:0], r[4:2], r[6:5]}, '0, 4'h0);
         end
      end
      end_test();

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
hw/cache_pkg.sv
hw/mem_bus_pkg.sv
hw/prio_encoder.sv
hw/cache_dmem.sv
hw/cache_ctrl.sv
hw/cache_top.sv
testbench/tb_cache.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
   --top-module tb_cache -o tb_cache > build.log 2>&1 \
   && ./obj_dir/tb_cache > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0
